// File: design/csc_coef_pkg.sv
package csc_coef_pkg;

	// Width of one Y, U or V sample and of one colour channel
	localparam int unsigned pix_w = 8;

	// Component after offset removal needs one extra bit for the sign
	localparam int unsigned comp_w = pix_w + 1;

	// Accumulator width of the multiply-accumulate stage
	localparam int unsigned acc_w = 32;

	// Saturation value for a channel that overflows
	localparam int unsigned pix_max = (1 << pix_w) - 1;

	// Black level of Y and centre of U and V
	localparam int y_offset = 16;
	localparam int c_offset = 128;

	// Coefficients in unsigned fixed point with frac_w fraction bits
	// Luma gain of about 1.164
	localparam int coef_y = 76284;
	// V into R, about 1.596
	localparam int coef_rv = 104595;
	// U into G, about 0.391
	localparam int coef_gu = 25624;
	// V into G, about 0.813
	localparam int coef_gv = 53281;
	// U into B, about 2.018
	localparam int coef_bu = 132251;

	localparam int unsigned frac_w = 16;

	// Clip fields of the accumulator, counted from bit 0
	// Colour byte sits right above the fraction
	localparam int unsigned col_lsb = frac_w;
	localparam int unsigned col_msb = col_lsb + pix_w - 1;

	// All bits between the colour byte and the sign flag overflow
	localparam int unsigned ovf_lsb = col_msb + 1;
	localparam int unsigned ovf_w = acc_w - 1 - ovf_lsb;

endpackage

// File: design/csc_types_pkg.sv
package csc_types_pkg;
	import csc_coef_pkg::*;

	// Raw sample on the way in, clipped colour on the way out
	typedef logic [pix_w-1:0] pixel_t;

	// Offset-corrected component
	// Y spans -16..239 and U, V span -128..127
	typedef logic signed [comp_w-1:0] comp_t;

	// One accumulator word read in two ways
	// acc is the signed sum built by the MAC stage
	// fld splits the same bits for saturation
	typedef union packed {
		logic signed [acc_w-1:0] acc;
		struct packed {
			// Set for a negative sum
			logic sign;
			// Any bit here means the result is above 255
			logic [ovf_w-1:0] ovf;
			// Integer part of the colour
			logic [pix_w-1:0] colour;
			// Dropped by the clip
			logic [frac_w-1:0] frac;
		} fld;
	} mac_word_u;

endpackage

// File: design/yuv_decode.sv
module yuv_decode
	import csc_coef_pkg::*, csc_types_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,

	// Pixel from the outside
	input logic in_valid,
	output logic in_ready,
	input pixel_t y,
	input pixel_t u,
	input pixel_t v,

	// Signed components towards the MAC stage
	output logic dec_valid,
	input logic dec_ready,
	output comp_t y_c,
	output comp_t u_c,
	output comp_t v_c
);

	logic load;
	comp_t y_sub;
	comp_t u_sub;
	comp_t v_sub;

	// Register empty, or drained by the next stage this cycle
	assign in_ready = !dec_valid || dec_ready;

	// Accepted transfer
	assign load = in_valid && in_ready;

	// Zero-extend to the signed width before the subtraction
	assign y_sub = comp_t'({1'b0, y}) - comp_t'(y_offset);
	assign u_sub = comp_t'({1'b0, u}) - comp_t'(c_offset);
	assign v_sub = comp_t'({1'b0, v}) - comp_t'(c_offset);

	// Occupancy of the decode register
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			dec_valid <= 1'b0;
		end else if (in_ready) begin
			// Fill on a new pixel, clear when drained without refill
			dec_valid <= in_valid;
		end
	end

	// Component registers
	always_ff @(posedge CLOCK_50_I) begin
		if (load) begin
			y_c <= y_sub;
			u_c <= u_sub;
			v_c <= v_sub;
		end
	end

endmodule

// File: design/csc_execute.sv
module csc_execute
	import csc_coef_pkg::*, csc_types_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,

	// Components from the decode stage
	input logic dec_valid,
	output logic dec_ready,
	input comp_t y_c,
	input comp_t u_c,
	input comp_t v_c,

	// Fixed-point sums towards the clip stage
	output logic exe_valid,
	input logic exe_ready,
	output mac_word_u r_acc,
	output mac_word_u g_acc,
	output mac_word_u b_acc
);

	logic load;

	// Products of each component with its coefficients
	logic signed [acc_w-1:0] luma_p;
	logic signed [acc_w-1:0] rv_p;
	logic signed [acc_w-1:0] gu_p;
	logic signed [acc_w-1:0] gv_p;
	logic signed [acc_w-1:0] bu_p;

	// Sums before the stage register
	mac_word_u r_sum;
	mac_word_u g_sum;
	mac_word_u b_sum;

	assign dec_ready = !exe_valid || exe_ready;
	assign load = dec_valid && dec_ready;

	// Luma product is common to all three channels
	assign luma_p = coef_y * acc_w'(y_c);

	// Chroma products, sign extended from the 9-bit components
	assign rv_p = coef_rv * acc_w'(v_c);
	assign gu_p = coef_gu * acc_w'(u_c);
	assign gv_p = coef_gv * acc_w'(v_c);
	assign bu_p = coef_bu * acc_w'(u_c);

	// Worst case stays well inside 32 signed bits
	always_comb begin
		r_sum.acc = luma_p + rv_p;
		g_sum.acc = luma_p - gu_p - gv_p;
		b_sum.acc = luma_p + bu_p;
	end

	// Occupancy of the execute register
	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			exe_valid <= 1'b0;
		end else if (dec_ready) begin
			exe_valid <= dec_valid;
		end
	end

	// Accumulator registers
	always_ff @(posedge CLOCK_50_I) begin
		if (load) begin
			r_acc <= r_sum;
			g_acc <= g_sum;
			b_acc <= b_sum;
		end
	end

endmodule

// File: design/rgb_result.sv
module rgb_result
	import csc_coef_pkg::*, csc_types_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,

	// Accumulators from the MAC stage
	input logic exe_valid,
	output logic exe_ready,
	input mac_word_u r_acc,
	input mac_word_u g_acc,
	input mac_word_u b_acc,

	// Final colour to the outside
	output logic out_valid,
	input logic out_ready,
	output pixel_t r,
	output pixel_t g,
	output pixel_t b
);

	logic load;
	pixel_t r_clip;
	pixel_t g_clip;
	pixel_t b_clip;

	// Saturate one accumulator to a colour byte
	function automatic pixel_t clip(input mac_word_u w);
		pixel_t c;
		if (w.fld.sign) begin
			c = '0;
		end else if (|w.fld.ovf) begin
			c = pixel_t'(pix_max);
		end else begin
			c = w.fld.colour;
		end
		return c;
	endfunction

	// Output register free, or taken by the sink this cycle
	assign exe_ready = !out_valid || out_ready;
	assign load = exe_valid && exe_ready;

	assign r_clip = clip(r_acc);
	assign g_clip = clip(g_acc);
	assign b_clip = clip(b_acc);

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			out_valid <= 1'b0;
		end else if (exe_ready) begin
			out_valid <= exe_valid;
		end
	end

	// Colour held while the sink stalls
	always_ff @(posedge CLOCK_50_I) begin
		if (load) begin
			r <= r_clip;
			g <= g_clip;
			b <= b_clip;
		end
	end

endmodule

// File: design/yuv2rgb_top.sv
module yuv2rgb_top
	import csc_types_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,

	// YUV input side
	input logic in_valid,
	output logic in_ready,
	input pixel_t y,
	input pixel_t u,
	input pixel_t v,

	// RGB output side
	output logic out_valid,
	input logic out_ready,
	output pixel_t r,
	output pixel_t g,
	output pixel_t b
);

	// Decode to execute
	logic dec_valid;
	logic dec_ready;
	comp_t y_c;
	comp_t u_c;
	comp_t v_c;

	// Execute to result
	logic exe_valid;
	logic exe_ready;
	mac_word_u r_acc;
	mac_word_u g_acc;
	mac_word_u b_acc;

	yuv_decode decode_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.y(y),
		.u(u),
		.v(v),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.y_c(y_c),
		.u_c(u_c),
		.v_c(v_c)
	);

	csc_execute execute_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.y_c(y_c),
		.u_c(u_c),
		.v_c(v_c),
		.exe_valid(exe_valid),
		.exe_ready(exe_ready),
		.r_acc(r_acc),
		.g_acc(g_acc),
		.b_acc(b_acc)
	);

	rgb_result result_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.exe_valid(exe_valid),
		.exe_ready(exe_ready),
		.r_acc(r_acc),
		.g_acc(g_acc),
		.b_acc(b_acc),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.r(r),
		.g(g),
		.b(b)
	);

endmodule

// File: verif/yuv2rgb_chk.sv
module yuv2rgb_chk
	import csc_types_pkg::*;
(
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input pixel_t r,
	input pixel_t g,
	input pixel_t b
);

	// No pixel leaves while reset is held
	reset_quiet: assert property (@(posedge CLOCK_50_I) !resetn |-> !out_valid)
		else $error("out_valid high while resetn is low");

	// Stalled output keeps valid and colour
	hold_stable: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		out_valid && !out_ready |=> out_valid && $stable(r) && $stable(g) && $stable(b))
		else $error("output pixel changed while the sink stalled");

	// Ready passes back through all three stages in the same cycle
	ready_chain: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		out_ready |-> in_ready)
		else $error("in_ready low while out_ready is high");

endmodule

// File: verif/tb_yuv2rgb.sv
module tb_yuv2rgb
	import csc_types_pkg::*;
();

	logic CLOCK_50_I;
	logic resetn;
	logic in_valid;
	logic in_ready;
	pixel_t y;
	pixel_t u;
	pixel_t v;
	logic out_valid;
	logic out_ready;
	pixel_t r;
	pixel_t g;
	pixel_t b;

	// Case table as read from the file
	string case_name[$];
	pixel_t case_y[$];
	pixel_t case_u[$];
	pixel_t case_v[$];
	pixel_t case_r[$];
	pixel_t case_g[$];
	pixel_t case_b[$];

	// Case index and input edge of every pixel in flight
	int exp_q[$];
	int in_edge_q[$];

	int seed;
	int cycle;
	int rx_count;
	int gap_errs;
	int lat_errs;
	int last_lat;
	int prev_out;
	int pass_count;
	int fail_count;
	bit loaded;
	string phase;

	yuv2rgb_top UUT (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.y(y),
		.u(u),
		.v(v),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.r(r),
		.g(g),
		.b(b)
	);

	bind yuv2rgb_top yuv2rgb_chk chk_unit (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.r(r),
		.g(g),
		.b(b)
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #10 CLOCK_50_I = ~CLOCK_50_I;
	end

	task automatic load_cases();
		int fd;
		string line;
		logic [127:0] nm;
		pixel_t cy;
		pixel_t cu;
		pixel_t cv;
		pixel_t cr;
		pixel_t cg;
		pixel_t cb;
		fd = $fopen("verif/yuv2rgb_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file verif/yuv2rgb_cases.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// Skip comment lines and blank lines
			if (line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %h %h %h %h %h %h",
						nm, cy, cu, cv, cr, cg, cb) == 7) begin
					case_name.push_back(string'(nm));
					case_y.push_back(cy);
					case_u.push_back(cu);
					case_v.push_back(cv);
					case_r.push_back(cr);
					case_g.push_back(cg);
					case_b.push_back(cb);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_reset();
		int bad;
		bad = 0;
		repeat (5) begin
			@(negedge CLOCK_50_I);
			if (out_valid != 1'b0 || in_ready != 1'b1) begin
				bad++;
			end
		end
		resetn = 1'b1;
		// Idle pipeline right after release
		repeat (2) begin
			@(negedge CLOCK_50_I);
			if (out_valid != 1'b0 || in_ready != 1'b1) begin
				bad++;
			end
		end
		if (bad != 0) begin
			$display("error reset: expected 0 bad cycles, actual %0d", bad);
			fail_count++;
		end else begin
			$display("ok reset");
			pass_count++;
		end
	endtask

	// Sends the first count cases and waits until all of them came out
	task automatic run_stream(input string label, input int count, input bit random_mode);
		int sent;
		bit pending;
		sent = 0;
		pending = 1'b0;
		phase = label;
		rx_count = 0;
		gap_errs = 0;
		lat_errs = 0;
		prev_out = -1;
		@(negedge CLOCK_50_I);
		while (rx_count < count) begin
			if (random_mode) begin
				out_ready = ($random(seed) & 3) != 0;
			end else begin
				out_ready = 1'b1;
			end
			// Valid and data stay put until the pixel is taken
			if (!pending) begin
				in_valid = 1'b0;
				if (sent < count && (!random_mode || ($random(seed) & 1) != 0)) begin
					y = case_y[sent];
					u = case_u[sent];
					v = case_v[sent];
					exp_q.push_back(sent);
					in_valid = 1'b1;
					pending = 1'b1;
				end
			end
			@(posedge CLOCK_50_I);
			if (pending && in_ready) begin
				pending = 1'b0;
				sent++;
			end
			@(negedge CLOCK_50_I);
		end
		in_valid = 1'b0;
		out_ready = 1'b1;
	endtask

	// Scoreboard on every output transfer
	always @(posedge CLOCK_50_I) begin
		int idx;
		cycle = cycle + 1;
		if (in_valid && in_ready) begin
			in_edge_q.push_back(cycle);
		end
		if (out_valid && out_ready) begin
			if (in_edge_q.size() == 0) begin
				$display("an output pixel came out that was never sent");
				fail_count++;
			end else begin
				idx = exp_q.pop_front();
				last_lat = cycle - in_edge_q.pop_front();
				if (last_lat != 3) begin
					lat_errs++;
				end
				if (prev_out >= 0 && cycle - prev_out != 1) begin
					gap_errs++;
				end
				prev_out = cycle;
				rx_count++;
				if (r != case_r[idx] || g != case_g[idx] || b != case_b[idx]) begin
					$display("error %s/%s: expected %h %h %h, actual %h %h %h", phase,
						case_name[idx], case_r[idx], case_g[idx], case_b[idx], r, g, b);
					fail_count++;
				end else begin
					$display("ok %s/%s rgb %h %h %h", phase, case_name[idx], r, g, b);
					pass_count++;
				end
			end
		end
	end

	// Budget grows with the number of cases
	initial begin
		wait (loaded);
		repeat (case_name.size() * 20 + 100) @(posedge CLOCK_50_I);
		$display("the run timed out before all pixels came out of the pipeline");
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 30;
		resetn = 1'b0;
		in_valid = 1'b0;
		y = '0;
		u = '0;
		v = '0;
		out_ready = 1'b1;
		cycle = 0;
		pass_count = 0;
		fail_count = 0;
		loaded = 1'b0;
		phase = "reset";
		load_cases();
		if (case_name.size() == 0) begin
			$display("no test cases could be read from the case file");
			fail_count++;
		end else begin
			loaded = 1'b1;
			check_reset();
			run_stream("single", 1, 1'b0);
			if (last_lat != 3) begin
				$display("error latency: expected 3 cycles, actual %0d", last_lat);
				fail_count++;
			end else begin
				$display("ok latency");
				pass_count++;
			end
			run_stream("stream", case_name.size(), 1'b0);
			if (gap_errs != 0 || lat_errs != 0) begin
				$display("error throughput: expected 0 gaps, actual %0d gaps and %0d late",
					gap_errs, lat_errs);
				fail_count++;
			end else begin
				$display("ok throughput");
				pass_count++;
			end
			run_stream("stall", case_name.size(), 1'b1);
			// Any stray output here is caught by the scoreboard
			repeat (5) @(negedge CLOCK_50_I);
		end
		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: verif/yuv2rgb_cases.txt
# name y u v r g b, all values as hex bytes
# r g b is the fixed-point conversion clipped to 0..255
grey 80 80 80 82 82 82
black 10 80 80 00 00 00
white eb 80 80 fe fe fe
y_max ff 80 80 ff ff ff
red 52 5a f0 ff 00 00
low_r 64 96 3c 00 90 8e
y16_vmax 10 00 ff ca 00 00
y16_umax 10 ff 00 00 36 ff
all_max ff ff ff ff 7d ff
y_max_uv_min ff 00 00 49 ff 13
y_zero 00 80 80 00 00 00
green 91 36 22 00 ff 00
blue 29 f0 6e 00 00 ff
warm b4 64 a0 f1 af 86
cool 3c c8 46 00 46 c4
pink c8 80 c8 ff 9b d6

// File: filelist.f
design/csc_coef_pkg.sv
design/csc_types_pkg.sv
design/yuv_decode.sv
design/csc_execute.sv
design/rgb_result.sv
design/yuv2rgb_top.sv
verif/yuv2rgb_chk.sv
verif/tb_yuv2rgb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_yuv2rgb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
